//--- source/rv_pkg.sv
`default_nettype none

package rv_pkg;

  // --------------------
  // Basic word types
  // --------------------

  // Data, address and instruction word
  typedef logic [31:0] word_t;
  // Register file index
  typedef logic [4:0] reg_idx_t;

  // --------------------
  // RV32I encodings
  // --------------------

  // Major opcodes of the kept subset
  localparam logic [6:0] OP_LUI    = 7'b0110111;
  localparam logic [6:0] OP_OPIMM  = 7'b0010011;
  localparam logic [6:0] OP_OP     = 7'b0110011;
  localparam logic [6:0] OP_BRANCH = 7'b1100011;
  localparam logic [6:0] OP_LOAD   = 7'b0000011;
  localparam logic [6:0] OP_STORE  = 7'b0100011;
  localparam logic [6:0] OP_SYSTEM = 7'b1110011;

  // ALU funct3 values, shared by OP and OP-IMM
  localparam logic [2:0] F3_ADD = 3'b000;
  localparam logic [2:0] F3_XOR = 3'b100;
  localparam logic [2:0] F3_OR  = 3'b110;
  localparam logic [2:0] F3_AND = 3'b111;

  // Branch funct3 values
  localparam logic [2:0] F3_BEQ = 3'b000;
  localparam logic [2:0] F3_BNE = 3'b001;

  // Memory access width in funct3
  localparam logic [2:0] F3_BYTE = 3'b000;
  localparam logic [2:0] F3_WORD = 3'b010;

  // funct7 that turns ADD into SUB
  localparam logic [6:0] F7_SUB = 7'b0100000;

  // The only SYSTEM word accepted
  localparam word_t INSTR_EBREAK = 32'h0010_0073;

  // --------------------
  // Control enums
  // --------------------

  typedef enum logic [2:0] {
    ALU_ADD    = 3'd0,
    ALU_SUB    = 3'd1,
    ALU_AND    = 3'd2,
    ALU_OR     = 3'd3,
    ALU_XOR    = 3'd4,
    ALU_PASS_B = 3'd5
  } alu_op_t;

  // Write-back source
  typedef enum logic {
    RES_ALU = 1'b0,
    RES_MEM = 1'b1
  } res_src_t;

endpackage

`default_nettype wire

//--- source/rv_fetch.sv
`timescale 1ns/1ns
`default_nettype none

module rv_fetch
  import rv_pkg::*;
#(
  parameter word_t RESET_PC = 32'h0000_0000
) (
  input  logic  clk,
  input  logic  rst_n,
  input  logic  halt,
  input  logic  branch_taken,
  input  word_t branch_target,
  output word_t pc,
  output logic  imem_ren
);

  word_t pc_next;

  // --------------------
  // Next PC choice
  // --------------------

  always_comb begin
    // Halt wins so the halting instruction stays on the bus
    if (halt) begin
      pc_next = pc;
    end else if (branch_taken) begin
      pc_next = branch_target;
    end else begin
      pc_next = pc + 32'd4;
    end
  end

  // PC register, one edge from next-PC inputs
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pc <= RESET_PC;
    end else begin
      pc <= pc_next;
    end
  end

  // Instruction port reads every cycle once out of reset
  assign imem_ren = rst_n;

endmodule

`default_nettype wire

//--- source/rv_regfile.sv
`timescale 1ns/1ns
`default_nettype none

module rv_regfile
  import rv_pkg::*;
(
  input  logic     clk,
  input  reg_idx_t rs1_idx,
  input  reg_idx_t rs2_idx,
  output word_t    rs1_data,
  output word_t    rs2_data,
  input  logic     reg_write,
  input  reg_idx_t rd_idx,
  input  word_t    rd_data
);

  // x1..x31 only, x0 has no storage
  word_t regs [1:31];

  // Write on the edge that ends the instruction
  always_ff @(posedge clk) begin
    if (reg_write && (rd_idx != 5'd0)) begin
      regs[rd_idx] <= rd_data;
    end
  end

  // Asynchronous reads, x0 forced to zero
  assign rs1_data = (rs1_idx == 5'd0) ? '0 : regs[rs1_idx];
  assign rs2_data = (rs2_idx == 5'd0) ? '0 : regs[rs2_idx];

endmodule

`default_nettype wire

//--- source/rv_decode.sv
`timescale 1ns/1ns
`default_nettype none

module rv_decode
  import rv_pkg::*;
(
  input  word_t    instr,
  output reg_idx_t rs1_idx,
  output reg_idx_t rs2_idx,
  output reg_idx_t rd_idx,
  output word_t    imm,
  output alu_op_t  alu_op,
  output logic     alu_src_imm,
  output logic     is_branch,
  output logic     branch_ne,
  output logic     mem_store,
  output logic     store_byte,
  output logic     mem_load,
  output res_src_t res_src,
  output logic     reg_write,
  output logic     ebreak,
  output logic     trap,
  output logic     halt
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  word_t      imm_i;
  word_t      imm_s;
  word_t      imm_b;
  word_t      imm_u;
  logic       wr_raw;
  logic       st_raw;
  logic       ld_raw;
  logic       br_raw;
  logic       illegal;
  logic       is_ebreak;

  // --------------------
  // Field split
  // --------------------

  assign opcode  = instr[6:0];
  assign rd_idx  = instr[11:7];
  assign funct3  = instr[14:12];
  assign rs1_idx = instr[19:15];
  assign rs2_idx = instr[24:20];
  assign funct7  = instr[31:25];

  // Sign-extended immediates per format
  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_u = {instr[31:12], 12'h000};

  // --------------------
  // Control decode
  // --------------------

  always_comb begin
    imm         = imm_i;
    alu_op      = ALU_ADD;
    alu_src_imm = 1'b0;
    br_raw      = 1'b0;
    branch_ne   = 1'b0;
    st_raw      = 1'b0;
    store_byte  = 1'b0;
    ld_raw      = 1'b0;
    res_src     = RES_ALU;
    wr_raw      = 1'b0;
    illegal     = 1'b0;
    is_ebreak   = 1'b0;

    case (opcode)
      OP_LUI: begin
        // Upper immediate goes straight through the ALU
        imm         = imm_u;
        alu_op      = ALU_PASS_B;
        alu_src_imm = 1'b1;
        wr_raw      = 1'b1;
      end
      OP_OPIMM: begin
        alu_src_imm = 1'b1;
        wr_raw      = 1'b1;
        case (funct3)
          F3_ADD:  alu_op = ALU_ADD;
          F3_XOR:  alu_op = ALU_XOR;
          F3_OR:   alu_op = ALU_OR;
          F3_AND:  alu_op = ALU_AND;
          default: illegal = 1'b1;
        endcase
      end
      OP_OP: begin
        wr_raw = 1'b1;
        case ({funct7, funct3})
          {7'b0000000, F3_ADD}: alu_op = ALU_ADD;
          {F7_SUB, F3_ADD}:     alu_op = ALU_SUB;
          {7'b0000000, F3_XOR}: alu_op = ALU_XOR;
          {7'b0000000, F3_OR}:  alu_op = ALU_OR;
          {7'b0000000, F3_AND}: alu_op = ALU_AND;
          default:              illegal = 1'b1;
        endcase
      end
      OP_BRANCH: begin
        imm = imm_b;
        case (funct3)
          F3_BEQ:  br_raw = 1'b1;
          F3_BNE: begin
            br_raw    = 1'b1;
            branch_ne = 1'b1;
          end
          default: illegal = 1'b1;
        endcase
      end
      OP_LOAD: begin
        // Word loads only
        alu_src_imm = 1'b1;
        res_src     = RES_MEM;
        if (funct3 == F3_WORD) begin
          ld_raw = 1'b1;
          wr_raw = 1'b1;
        end else begin
          illegal = 1'b1;
        end
      end
      OP_STORE: begin
        imm         = imm_s;
        alu_src_imm = 1'b1;
        case (funct3)
          F3_WORD: st_raw = 1'b1;
          F3_BYTE: begin
            st_raw     = 1'b1;
            store_byte = 1'b1;
          end
          default: illegal = 1'b1;
        endcase
      end
      OP_SYSTEM: begin
        if (instr == INSTR_EBREAK) begin
          is_ebreak = 1'b1;
        end else begin
          illegal = 1'b1;
        end
      end
      default: illegal = 1'b1;
    endcase
  end

  // --------------------
  // Halt and side-effect gating
  // --------------------

  assign ebreak = is_ebreak;
  assign trap   = illegal;
  assign halt   = is_ebreak || illegal;

  // Nothing commits while halting, x0 writes are dropped here as well
  assign reg_write = wr_raw && !halt && (rd_idx != 5'd0);
  assign mem_store = st_raw && !halt;
  assign mem_load  = ld_raw && !halt;
  assign is_branch = br_raw && !halt;

endmodule

`default_nettype wire

//--- source/rv_execute.sv
`timescale 1ns/1ns
`default_nettype none

module rv_execute
  import rv_pkg::*;
(
  input  word_t   pc,
  input  word_t   rs1_data,
  input  word_t   rs2_data,
  input  word_t   imm,
  input  alu_op_t alu_op,
  input  logic    alu_src_imm,
  input  logic    is_branch,
  input  logic    branch_ne,
  output word_t   alu_result,
  output logic    branch_taken,
  output word_t   branch_target
);

  word_t op_b;
  logic  rs_equal;

  // --------------------
  // ALU
  // --------------------

  // Immediate or rs2 as second operand
  assign op_b = alu_src_imm ? imm : rs2_data;

  always_comb begin
    case (alu_op)
      ALU_ADD:    alu_result = rs1_data + op_b;
      ALU_SUB:    alu_result = rs1_data - op_b;
      ALU_AND:    alu_result = rs1_data & op_b;
      ALU_OR:     alu_result = rs1_data | op_b;
      ALU_XOR:    alu_result = rs1_data ^ op_b;
      // LUI result is the U immediate itself
      ALU_PASS_B: alu_result = op_b;
      default:    alu_result = '0;
    endcase
  end

  // --------------------
  // Branch
  // --------------------

  // Register compare, independent of the ALU operand mux
  assign rs_equal = (rs1_data == rs2_data);

  // BNE inverts the sense of the compare
  assign branch_taken = is_branch && (branch_ne ? !rs_equal : rs_equal);

  // PC-relative target from the B immediate
  assign branch_target = pc + imm;

endmodule

`default_nettype wire

//--- source/rv_mem_wb.sv
`timescale 1ns/1ns
`default_nettype none

module rv_mem_wb
  import rv_pkg::*;
(
  input  word_t      alu_result,
  input  word_t      rs2_data,
  input  logic       mem_store,
  input  logic       store_byte,
  input  logic       mem_load,
  input  res_src_t   res_src,
  output logic       dmem_ren,
  output word_t      dmem_raddr,
  input  word_t      dmem_rdata,
  output logic       dmem_we,
  output word_t      dmem_waddr,
  output word_t      dmem_wdata,
  output logic [3:0] dmem_wstrb,
  output word_t      rd_data
);

  word_t addr_word;

  // Word-aligned address, byte offset goes into the strobe
  assign addr_word = {alu_result[31:2], 2'b00};

  // --------------------
  // Data memory ports
  // --------------------

  assign dmem_ren   = mem_load;
  assign dmem_raddr = addr_word;
  assign dmem_we    = mem_store;
  assign dmem_waddr = addr_word;

  // SB puts the byte on every lane, strobe picks the one
  assign dmem_wdata = store_byte ? {4{rs2_data[7:0]}} : rs2_data;

  always_comb begin
    if (!mem_store) begin
      dmem_wstrb = 4'b0000;
    end else if (store_byte) begin
      dmem_wstrb = 4'b0001 << alu_result[1:0];
    end else begin
      dmem_wstrb = 4'b1111;
    end
  end

  // --------------------
  // Write-back select
  // --------------------

  // Loaded word arrives in the same cycle
  assign rd_data = (res_src == RES_MEM) ? dmem_rdata : alu_result;

endmodule

`default_nettype wire

//--- source/rv_core.sv
`timescale 1ns/1ns
`default_nettype none

module rv_core
  import rv_pkg::*;
#(
  parameter word_t RESET_PC = 32'h0000_0000
) (
  input  logic       clk,
  input  logic       rst_n,
  output logic       imem_ren,
  output word_t      imem_raddr,
  input  word_t      imem_rdata,
  output logic       dmem_ren,
  output word_t      dmem_raddr,
  input  word_t      dmem_rdata,
  output logic       dmem_we,
  output word_t      dmem_waddr,
  output word_t      dmem_wdata,
  output logic [3:0] dmem_wstrb,
  output logic       ebreak,
  output logic       trap
);

  // ADDI x0, x0, 0 shown to decode while the fetch port is idle
  localparam word_t NOP = 32'h0000_0013;

  word_t    pc;
  word_t    instr;
  logic     halt;
  reg_idx_t rs1_idx;
  reg_idx_t rs2_idx;
  reg_idx_t rd_idx;
  word_t    rs1_data;
  word_t    rs2_data;
  word_t    rd_data;
  word_t    imm;
  alu_op_t  alu_op;
  logic     alu_src_imm;
  logic     is_branch;
  logic     branch_ne;
  logic     mem_store;
  logic     store_byte;
  logic     mem_load;
  res_src_t res_src;
  logic     reg_write;
  word_t    alu_result;
  logic     branch_taken;
  word_t    branch_target;

  // --------------------
  // IF
  // --------------------

  rv_fetch #(
    .RESET_PC(RESET_PC)
  ) fetch_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .halt         (halt),
    .branch_taken (branch_taken),
    .branch_target(branch_target),
    .pc           (pc),
    .imem_ren     (imem_ren)
  );

  assign imem_raddr = pc;

  // Read data only counts while the port is enabled
  assign instr = imem_ren ? imem_rdata : NOP;

  // --------------------
  // ID and register file
  // --------------------

  rv_decode decode_i (
    .instr      (instr),
    .rs1_idx    (rs1_idx),
    .rs2_idx    (rs2_idx),
    .rd_idx     (rd_idx),
    .imm        (imm),
    .alu_op     (alu_op),
    .alu_src_imm(alu_src_imm),
    .is_branch  (is_branch),
    .branch_ne  (branch_ne),
    .mem_store  (mem_store),
    .store_byte (store_byte),
    .mem_load   (mem_load),
    .res_src    (res_src),
    .reg_write  (reg_write),
    .ebreak     (ebreak),
    .trap       (trap),
    .halt       (halt)
  );

  rv_regfile regfile_i (
    .clk      (clk),
    .rs1_idx  (rs1_idx),
    .rs2_idx  (rs2_idx),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .reg_write(reg_write),
    .rd_idx   (rd_idx),
    .rd_data  (rd_data)
  );

  // --------------------
  // EX, MEM and WB
  // --------------------

  rv_execute execute_i (
    .pc           (pc),
    .rs1_data     (rs1_data),
    .rs2_data     (rs2_data),
    .imm          (imm),
    .alu_op       (alu_op),
    .alu_src_imm  (alu_src_imm),
    .is_branch    (is_branch),
    .branch_ne    (branch_ne),
    .alu_result   (alu_result),
    .branch_taken (branch_taken),
    .branch_target(branch_target)
  );

  rv_mem_wb mem_wb_i (
    .alu_result(alu_result),
    .rs2_data  (rs2_data),
    .mem_store (mem_store),
    .store_byte(store_byte),
    .mem_load  (mem_load),
    .res_src   (res_src),
    .dmem_ren  (dmem_ren),
    .dmem_raddr(dmem_raddr),
    .dmem_rdata(dmem_rdata),
    .dmem_we   (dmem_we),
    .dmem_waddr(dmem_waddr),
    .dmem_wdata(dmem_wdata),
    .dmem_wstrb(dmem_wstrb),
    .rd_data   (rd_data)
  );

endmodule

`default_nettype wire

//--- verification/rv_core_asserts.sv
`timescale 1ns/1ns
`default_nettype none

module rv_core_asserts
  import rv_pkg::*;
(
  input logic       clk,
  input logic       rst_n,
  input logic       dmem_we,
  input logic [3:0] dmem_wstrb,
  input logic       ebreak,
  input logic       trap,
  input word_t      imem_raddr
);

  // --------------------
  // Halt behavior
  // --------------------

  // A halting instruction never commits a store
  a_no_store_on_halt: assert property (@(posedge clk) disable iff (!rst_n)
    (ebreak || trap) |-> !dmem_we)
    else $error("dmem_we high while halted");

  // PC frozen while halted
  a_pc_frozen: assert property (@(posedge clk) disable iff (!rst_n)
    (ebreak || trap) |=> $stable(imem_raddr))
    else $error("imem_raddr changed while halted");

  // --------------------
  // Bus shape
  // --------------------

  a_fetch_aligned: assert property (@(posedge clk) disable iff (!rst_n)
    imem_raddr[1:0] == 2'b00)
    else $error("imem_raddr not word aligned");

  // Full word or a single byte lane
  a_strobe_shape: assert property (@(posedge clk) disable iff (!rst_n)
    dmem_we |-> ((dmem_wstrb == 4'b1111) || $onehot(dmem_wstrb)))
    else $error("dmem_wstrb neither full nor one-hot");

endmodule

`default_nettype wire

//--- verification/rv_core_checker.sv
`timescale 1ns/1ns
`default_nettype none

module rv_core_checker
  import rv_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  logic       imem_ren,
  input  logic       dmem_ren,
  input  logic       dmem_we,
  input  word_t      dmem_waddr,
  input  word_t      dmem_wdata,
  input  logic [3:0] dmem_wstrb,
  input  logic       ebreak,
  input  logic       trap,
  input  word_t      imem_raddr,
  output int         errors
);

  word_t      exp_addr [4];
  word_t      exp_data [4];
  logic [3:0] exp_strb [4];
  int         exp_count;
  logic       want_trap;
  logic       active;
  int         store_idx;
  logic       seen_ebreak;
  logic       seen_trap;
  logic       halted;
  word_t      frozen_pc;
  int         test_errs;
  int         tests_run;
  int         tests_failed;
  word_t      lane_mask;

  initial begin
    errors       = 0;
    active       = 1'b0;
    tests_run    = 0;
    tests_failed = 0;
  end

  // --------------------
  // Per-test setup from the tb table
  // --------------------

  task automatic start_test(input int count, input logic is_trap);
    exp_count   = count;
    want_trap   = is_trap;
    store_idx   = 0;
    seen_ebreak = 1'b0;
    seen_trap   = 1'b0;
    halted      = 1'b0;
    test_errs   = 0;
    active      = 1'b1;
  endtask

  task automatic expect_store(input int k, input word_t a, input word_t d, input logic [3:0] s);
    exp_addr[k] = a;
    exp_data[k] = d;
    exp_strb[k] = s;
  endtask

  task automatic note_error();
    test_errs = test_errs + 1;
    errors    = errors + 1;
  endtask

  // --------------------
  // Store and halt monitor
  // --------------------

  always @(posedge clk) begin
    if (active && !rst_n) begin
      // Nothing fetched, read, written or halted under reset
      if (imem_ren || dmem_ren || dmem_we || ebreak || trap) begin
        $display("ERROR t=%0t core ports not idle during reset", $time);
        note_error();
      end
    end
    if (active && rst_n) begin
      // Fetch port reads on every cycle out of reset
      if (!imem_ren) begin
        $display("MISMATCH t=%0t imem_ren expected 1 got 0", $time);
        note_error();
      end
      if (dmem_we) begin
        if (store_idx >= exp_count) begin
          $display("ERROR t=%0t unexpected extra store to address %h", $time, dmem_waddr);
          note_error();
        end else begin
          // Only lanes enabled by the expected strobe carry data
          lane_mask = {{8{exp_strb[store_idx][3]}}, {8{exp_strb[store_idx][2]}},
                       {8{exp_strb[store_idx][1]}}, {8{exp_strb[store_idx][0]}}};
          if (dmem_waddr != exp_addr[store_idx]) begin
            $display("MISMATCH t=%0t dmem_waddr expected %h got %h",
                     $time, exp_addr[store_idx], dmem_waddr);
            note_error();
          end
          if (dmem_wstrb != exp_strb[store_idx]) begin
            $display("MISMATCH t=%0t dmem_wstrb expected %b got %b",
                     $time, exp_strb[store_idx], dmem_wstrb);
            note_error();
          end
          if ((dmem_wdata & lane_mask) != (exp_data[store_idx] & lane_mask)) begin
            $display("MISMATCH t=%0t dmem_wdata expected %h got %h",
                     $time, exp_data[store_idx] & lane_mask, dmem_wdata & lane_mask);
            note_error();
          end
          store_idx = store_idx + 1;
        end
      end
      if (halted && (imem_raddr != frozen_pc)) begin
        $display("ERROR t=%0t fetch address moved after halt", $time);
        note_error();
      end
      if (ebreak) seen_ebreak = 1'b1;
      if (trap) seen_trap = 1'b1;
      // First halting edge fixes the PC to compare against
      if ((ebreak || trap) && !halted) begin
        halted    = 1'b1;
        frozen_pc = imem_raddr;
      end
    end
  end

  // --------------------
  // End of test and summary
  // --------------------

  task automatic end_test(input string name);
    active = 1'b0;
    if (store_idx < exp_count) begin
      $display("ERROR only %0d of %0d expected stores seen", store_idx, exp_count);
      note_error();
    end
    if (!seen_ebreak && !seen_trap) begin
      $display("ERROR core never halted");
      note_error();
    end else if (want_trap && !seen_trap) begin
      $display("ERROR expected a trap but the core halted on ebreak");
      note_error();
    end else if (!want_trap && !seen_ebreak) begin
      $display("ERROR expected ebreak but the core trapped");
      note_error();
    end
    tests_run = tests_run + 1;
    if (test_errs == 0) begin
      $display("PASS %s", name);
    end else begin
      tests_failed = tests_failed + 1;
      $display("FAIL %s with %0d errors", name, test_errs);
    end
  endtask

  task automatic report();
    $display("Tests run %0d, passed %0d, failed %0d, errors %0d",
             tests_run, tests_run - tests_failed, tests_failed, errors);
  endtask

endmodule

`default_nettype wire

//--- verification/rv_core_tb.sv
`timescale 1ns/1ns
`default_nettype none

module rv_core_tb
  import rv_pkg::*;
;

  localparam int NUM_TESTS = 7;
  // Reset, 16-cycle run and one cycle of margin per test
  localparam int CYCLE_LIMIT = NUM_TESTS * 22;

  logic       clk;
  logic       rst_n;
  logic       imem_ren;
  word_t      imem_raddr;
  word_t      imem_rdata;
  logic       dmem_ren;
  word_t      dmem_raddr;
  word_t      dmem_rdata;
  logic       dmem_we;
  word_t      dmem_waddr;
  word_t      dmem_wdata;
  logic [3:0] dmem_wstrb;
  logic       ebreak;
  logic       trap;
  int         errors;
  int         cycles;

  // Program table
  string      names     [NUM_TESTS];
  word_t      prog      [NUM_TESTS][16];
  word_t      st_addr   [NUM_TESTS][4];
  word_t      st_data   [NUM_TESTS][4];
  logic [3:0] st_strb   [NUM_TESTS][4];
  int         st_count  [NUM_TESTS];
  logic       halt_trap [NUM_TESTS];
  int         cur;
  int         fill;

  word_t imem [16];
  word_t dmem [64];

  rv_core #(
    .RESET_PC(32'h0000_0000)
  ) dut_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .imem_ren  (imem_ren),
    .imem_raddr(imem_raddr),
    .imem_rdata(imem_rdata),
    .dmem_ren  (dmem_ren),
    .dmem_raddr(dmem_raddr),
    .dmem_rdata(dmem_rdata),
    .dmem_we   (dmem_we),
    .dmem_waddr(dmem_waddr),
    .dmem_wdata(dmem_wdata),
    .dmem_wstrb(dmem_wstrb),
    .ebreak    (ebreak),
    .trap      (trap)
  );

  rv_core_checker chk_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .imem_ren  (imem_ren),
    .dmem_ren  (dmem_ren),
    .dmem_we   (dmem_we),
    .dmem_waddr(dmem_waddr),
    .dmem_wdata(dmem_wdata),
    .dmem_wstrb(dmem_wstrb),
    .ebreak    (ebreak),
    .trap      (trap),
    .imem_raddr(imem_raddr),
    .errors    (errors)
  );

  bind rv_core rv_core_asserts asserts_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .dmem_we   (dmem_we),
    .dmem_wstrb(dmem_wstrb),
    .ebreak    (ebreak),
    .trap      (trap),
    .imem_raddr(imem_raddr)
  );

  // --------------------
  // Clock, watchdog and memories
  // --------------------

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  initial cycles = 0;

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("Run stopped after %0d cycles without finishing the tests", cycles);
      $display("Result: FAILED");
      $finish;
    end
  end

  // Zero-latency reads
  assign imem_rdata = imem[imem_raddr[5:2]];
  // Data port returns zero unless the read is enabled
  assign dmem_rdata = dmem_ren ? dmem[dmem_raddr[7:2]] : 32'h0000_0000;

  // Byte-lane writes on the edge
  always @(posedge clk) begin
    if (dmem_we) begin
      for (int b = 0; b < 4; b++) begin
        if (dmem_wstrb[b]) dmem[dmem_waddr[7:2]][8*b +: 8] = dmem_wdata[8*b +: 8];
      end
    end
  end

  // --------------------
  // RV32I encoders
  // --------------------

  function automatic word_t i_word(input logic [6:0] op, input logic [2:0] f3,
                                   input int rd, input int rs1, input int imm);
    logic [31:0] d;
    logic [31:0] s;
    logic [31:0] v;
    d = rd;
    s = rs1;
    v = imm;
    return {v[11:0], s[4:0], f3, d[4:0], op};
  endfunction

  function automatic word_t r_word(input logic [6:0] f7, input logic [2:0] f3,
                                   input int rd, input int rs1, input int rs2);
    logic [31:0] d;
    logic [31:0] s;
    logic [31:0] t;
    d = rd;
    s = rs1;
    t = rs2;
    return {f7, t[4:0], s[4:0], f3, d[4:0], OP_OP};
  endfunction

  function automatic word_t s_word(input logic [2:0] f3, input int rs1, input int rs2,
                                   input int imm);
    logic [31:0] s;
    logic [31:0] t;
    logic [31:0] v;
    s = rs1;
    t = rs2;
    v = imm;
    return {v[11:5], t[4:0], s[4:0], f3, v[4:0], OP_STORE};
  endfunction

  // B format scatters the offset bits
  function automatic word_t b_word(input logic [2:0] f3, input int rs1, input int rs2,
                                   input int off);
    logic [31:0] s;
    logic [31:0] t;
    logic [31:0] o;
    s = rs1;
    t = rs2;
    o = off;
    return {o[12], o[10:5], t[4:0], s[4:0], f3, o[4:1], o[11], OP_BRANCH};
  endfunction

  function automatic word_t u_word(input int rd, input int imm20);
    logic [31:0] d;
    logic [31:0] v;
    d = rd;
    v = imm20;
    return {v[19:0], d[4:0], OP_LUI};
  endfunction

  // --------------------
  // Table building
  // --------------------

  task automatic entry(input int t, input string name, input logic is_trap);
    cur           = t;
    fill          = 0;
    names[t]      = name;
    halt_trap[t]  = is_trap;
    st_count[t]   = 0;
    // Unused slots hold opcode zero, which traps
    for (int i = 0; i < 16; i++) prog[t][i] = 32'h0000_0000;
  endtask

  task automatic put(input word_t w);
    prog[cur][fill] = w;
    fill = fill + 1;
  endtask

  task automatic want(input word_t a, input word_t d, input logic [3:0] s);
    st_addr[cur][st_count[cur]] = a;
    st_data[cur][st_count[cur]] = d;
    st_strb[cur][st_count[cur]] = s;
    st_count[cur] = st_count[cur] + 1;
  endtask

  task automatic build_table();
    entry(0, "add_sub_x0", 1'b0);
    put(i_word(OP_OPIMM, F3_ADD, 1, 0, 100));
    put(i_word(OP_OPIMM, F3_ADD, 2, 0, -7));
    put(r_word(7'b0000000, F3_ADD, 3, 1, 2));
    put(r_word(F7_SUB, F3_ADD, 4, 2, 1));
    put(r_word(7'b0000000, F3_ADD, 0, 1, 2));
    put(s_word(F3_WORD, 0, 3, 0));
    put(s_word(F3_WORD, 0, 4, 4));
    put(s_word(F3_WORD, 0, 0, 8));
    put(INSTR_EBREAK);
    want(32'd0, 32'd93, 4'hF);
    want(32'd4, 32'hFFFF_FF95, 4'hF);
    want(32'd8, 32'd0, 4'hF);

    entry(1, "lui_logic", 1'b0);
    put(u_word(1, 32'h12345));
    put(i_word(OP_OPIMM, F3_OR, 2, 1, 32'h0F0));
    put(i_word(OP_OPIMM, F3_AND, 3, 2, 32'h0FF));
    put(i_word(OP_OPIMM, F3_XOR, 4, 2, -1));
    put(r_word(7'b0000000, F3_AND, 5, 2, 1));
    put(r_word(7'b0000000, F3_OR, 6, 1, 3));
    put(r_word(7'b0000000, F3_XOR, 7, 2, 4));
    put(s_word(F3_WORD, 0, 4, 16));
    put(s_word(F3_WORD, 0, 5, 20));
    put(s_word(F3_WORD, 0, 6, 24));
    put(s_word(F3_WORD, 0, 7, 28));
    put(INSTR_EBREAK);
    want(32'd16, 32'hEDCB_AF0F, 4'hF);
    want(32'd20, 32'h1234_5000, 4'hF);
    want(32'd24, 32'h1234_50F0, 4'hF);
    want(32'd28, 32'hFFFF_FFFF, 4'hF);

    // Taken branches hop over the store right behind them
    entry(2, "beq_bne", 1'b0);
    put(i_word(OP_OPIMM, F3_ADD, 1, 0, 5));
    put(i_word(OP_OPIMM, F3_ADD, 2, 0, 5));
    put(b_word(F3_BEQ, 1, 2, 8));
    put(s_word(F3_WORD, 0, 1, 32));
    put(b_word(F3_BNE, 1, 2, 8));
    put(s_word(F3_WORD, 0, 1, 36));
    put(i_word(OP_OPIMM, F3_ADD, 3, 0, 9));
    put(b_word(F3_BNE, 1, 3, 8));
    put(s_word(F3_WORD, 0, 3, 40));
    put(b_word(F3_BEQ, 1, 3, 8));
    put(s_word(F3_WORD, 0, 3, 44));
    put(INSTR_EBREAK);
    want(32'd36, 32'd5, 4'hF);
    want(32'd44, 32'd9, 4'hF);

    entry(3, "sw_lw", 1'b0);
    put(i_word(OP_OPIMM, F3_ADD, 1, 0, 32'h123));
    put(s_word(F3_WORD, 0, 1, 48));
    put(i_word(OP_LOAD, F3_WORD, 2, 0, 48));
    put(i_word(OP_OPIMM, F3_ADD, 3, 2, -3));
    put(s_word(F3_WORD, 0, 3, 52));
    put(INSTR_EBREAK);
    want(32'd48, 32'h0000_0123, 4'hF);
    want(32'd52, 32'h0000_0120, 4'hF);

    entry(4, "sb_lanes", 1'b0);
    put(i_word(OP_OPIMM, F3_ADD, 1, 0, 32'h5A));
    put(i_word(OP_OPIMM, F3_ADD, 2, 0, 32'hA5));
    put(s_word(F3_BYTE, 0, 1, 64));
    put(s_word(F3_BYTE, 0, 2, 65));
    put(s_word(F3_BYTE, 0, 1, 66));
    put(s_word(F3_BYTE, 0, 2, 67));
    put(INSTR_EBREAK);
    want(32'd64, 32'h0000_005A, 4'b0001);
    want(32'd64, 32'h0000_A500, 4'b0010);
    want(32'd64, 32'h005A_0000, 4'b0100);
    want(32'd64, 32'hA500_0000, 4'b1000);

    entry(5, "illegal_trap", 1'b1);
    put(i_word(OP_OPIMM, F3_ADD, 1, 0, 1));
    put(s_word(F3_WORD, 0, 1, 80));
    put(32'hFFFF_FFFF);
    put(s_word(F3_WORD, 0, 1, 84));
    want(32'd80, 32'd1, 4'hF);

    entry(6, "ebreak_halt", 1'b0);
    put(i_word(OP_OPIMM, F3_ADD, 1, 0, 2));
    put(INSTR_EBREAK);
    put(s_word(F3_WORD, 0, 1, 88));
  endtask

  // --------------------
  // Test runner
  // --------------------

  task automatic run_test(input int t);
    int n;
    @(posedge clk);
    #10;
    rst_n = 1'b0;
    for (int i = 0; i < 16; i++) imem[i] = prog[t][i];
    for (int j = 0; j < 64; j++) dmem[j] = $urandom;
    chk_i.start_test(st_count[t], halt_trap[t]);
    for (int k = 0; k < st_count[t]; k++) begin
      chk_i.expect_store(k, st_addr[t][k], st_data[t][k], st_strb[t][k]);
    end
    repeat (5) @(posedge clk);
    #10;
    rst_n = 1'b1;
    n = 0;
    while ((n < 16) && !(ebreak || trap)) begin
      @(posedge clk);
      #10;
      n = n + 1;
    end
    // Two more edges so the checker notes the halt PC and then sees it hold
    if (ebreak || trap) begin
      repeat (2) @(posedge clk);
      #10;
    end
    chk_i.end_test(names[t]);
  endtask

  initial begin
    rst_n = 1'b0;
    void'($urandom(7142));
    for (int i = 0; i < 16; i++) imem[i] = 32'h0000_0000;
    for (int j = 0; j < 64; j++) dmem[j] = 32'h0000_0000;
    build_table();
    for (int t = 0; t < NUM_TESTS; t++) run_test(t);
    chk_i.report();
    if (errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- rv_core.f
source/rv_pkg.sv
source/rv_fetch.sv
source/rv_regfile.sv
source/rv_decode.sv
source/rv_execute.sv
source/rv_mem_wb.sv
source/rv_core.sv
verification/rv_core_asserts.sv
verification/rv_core_checker.sv
verification/rv_core_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build the rv_core testbench with Verilator, run it, and look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f rv_core.f --top-module rv_core_tb \
  -o rv_core_sim > build.log 2>&1 &&
./obj_dir/rv_core_sim > sim.log 2>&1 ||
{ echo "Build or simulation failed, see build.log and sim.log"; exit 1; }

grep -q "^Result: PASSED$" sim.log && exit 0 || exit 1
